// File: all.f
+incdir+src
src/icache_pkg.sv
src/icache_if.sv
src/icache_req_buf.sv
src/icache_store.sv
src/icache_ctrl.sv
src/icache_fetch_out.sv
src/icache_top.sv
sim/icache_tb.sv

// File: sim/icache_input.txt
# op addr word0 word1 second_valid miss, all hex
# op 0 is a fetch, op 1 an invalidate whose expected columns are unused
0 00001000 5a5a1000 5a5a1004 1 1
0 00001004 5a5a1004 5a5a1008 1 0
0 00001008 5a5a1008 5a5a100c 1 0
0 0000100c 5a5a100c 00000013 0 0
0 00002020 5a5a2020 5a5a2024 1 1
0 00003024 5a5a3024 5a5a3028 1 1
0 00002028 5a5a2028 5a5a202c 1 0
0 0000402c 5a5a402c 00000013 0 1
0 00002020 5a5a2020 5a5a2024 1 0
0 00003020 5a5a3020 5a5a3024 1 1
1 00000000 00000000 00000000 0 0
0 00001004 5a5a1004 5a5a1008 1 1
0 00002024 5a5a2024 5a5a2028 1 1
0 00001000 5a5a1000 5a5a1004 1 0
0 00001008 5a5a1008 5a5a100c 1 0
0 00002020 5a5a2020 5a5a2024 1 0
0 000050f0 5a5a50f0 5a5a50f4 1 1
0 000050fc 5a5a50fc 00000013 0 0
0 00001004 5a5a1004 5a5a1008 1 0
0 00006050 5a5a6050 5a5a6054 1 1
0 00006058 5a5a6058 5a5a605c 1 0
1 00000000 00000000 00000000 0 0
0 00006054 5a5a6054 5a5a6058 1 1
0 00001000 5a5a1000 5a5a1004 1 1
0 0000100c 5a5a100c 00000013 0 0

// File: sim/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

    localparam int MAX_REQ    = 64;
    localparam int WAIT_LIMIT = 300;
    localparam int DRAIN      = 8;

    logic              clk;
    logic              arst_n;
    logic              req_valid;
    logic              req_ready;
    logic [31:0]       req_addr;
    logic              req_op;
    logic              out_valid;
    logic              out_ready;
    logic [63:0]       out_pair;
    logic              out_second_valid;
    logic              mem_req;
    logic [31:0]       mem_addr;
    logic              mem_addr_ok;
    logic              mem_data_ok;
    icache_pkg::line_t mem_line;

    // one row per request from the data file
    logic        f_op   [0:MAX_REQ-1];
    logic [31:0] f_addr [0:MAX_REQ-1];
    logic [63:0] f_pair [0:MAX_REQ-1];
    logic        f_sv   [0:MAX_REQ-1];
    logic        f_miss [0:MAX_REQ-1];
    int          miss_ord [0:MAX_REQ-1];

    logic [31:0] lfsr;
    int          n_req, next_req, n_miss, hs_count, errors, n_pass, n_fail;
    int          idle, drain, mem_phase, mem_wait;
    logic        progress, timed_out, file_ok, stalled, held_sv;
    logic [63:0] held_pair;
    logic [31:0] mem_line_addr;
    int          pending [$];
    logic [31:0] miss_lines [$];

    icache_top i_dut (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr), .req_op(req_op),
        .out_valid(out_valid), .out_ready(out_ready), .out_pair(out_pair),
        .out_second_valid(out_second_valid),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int draw(input int nbits);
        int   v;
        logic fb;
        v = 0;
        for (int i = 0; i < nbits; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    task automatic read_requests();
        int          fd;
        int          cnt;
        string       text;
        logic [31:0] op, addr, w0, w1, sv, miss;
        n_req = 0;
        fd    = $fopen("sim/icache_input.txt", "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            while (!$feof(fd) && n_req < MAX_REQ) begin
                text = "";
                void'($fgets(text, fd));
                cnt = $sscanf(text, "%h %h %h %h %h %h", op, addr, w0, w1, sv, miss);
                if (text.len() > 0 && text[0] != "#" && cnt == 6) begin
                    f_op[n_req]   = op[0];
                    f_addr[n_req] = addr;
                    f_pair[n_req] = {w1, w0};
                    f_sv[n_req]   = sv[0];
                    f_miss[n_req] = miss[0];
                    n_req++;
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // sampled at the falling edge
    //////////////////////////////
    task automatic check_cycle();
        int id;
        int err0;
        if (mem_req && mem_addr_ok) begin
            if (miss_lines.size() == 0) begin
                $display("memory request for %h while no miss was expected", mem_addr);
                errors++;
            end else begin
                assert (mem_addr == miss_lines[0]) else begin
                    $display("mismatch mem_addr: got %h expected %h", mem_addr, miss_lines[0]);
                    errors++;
                end
                void'(miss_lines.pop_front());
            end
            hs_count++;
        end
        if (req_valid && req_ready) begin
            if (f_op[next_req]) begin
                $display("req %0d invalidate accepted", next_req);
                n_pass++;
            end else begin
                pending.push_back(next_req);
                if (f_miss[next_req]) begin
                    miss_lines.push_back({f_addr[next_req][31:4], 4'h0});
                    miss_ord[next_req] = n_miss++;
                end
            end
            next_req++;
            progress = 1'b1;
        end
        if (stalled) begin
            assert (out_valid && out_pair == held_pair && out_second_valid == held_sv) else begin
                $display("output changed or dropped while out_ready was low");
                errors++;
            end
        end
        stalled   = out_valid && !out_ready;
        held_pair = out_pair;
        held_sv   = out_second_valid;
        if (out_valid && out_ready) begin
            progress = 1'b1;
            if (pending.size() == 0) begin
                $display("output %h appeared with no fetch outstanding", out_pair);
                errors++;
            end else begin
                id   = pending.pop_front();
                err0 = errors;
                assert (out_pair == f_pair[id]) else begin
                    $display("mismatch out_pair: got %h expected %h", out_pair, f_pair[id]);
                    errors++;
                end
                assert (out_second_valid == f_sv[id]) else begin
                    $display("mismatch out_second_valid: got %h expected %h",
                             out_second_valid, f_sv[id]);
                    errors++;
                end
                if (f_miss[id]) begin
                    assert (hs_count > miss_ord[id]) else begin
                        $display("request %0d answered without a memory refill", id);
                        errors++;
                    end
                end
                if (errors == err0) n_pass++;
                else n_fail++;
                $display("req %0d fetch %h pair %h second %b miss %b %s", id, f_addr[id],
                         out_pair, out_second_valid, f_miss[id],
                         (errors == err0) ? "ok" : "FAIL");
            end
        end
    endtask

    // driven half a ns after the rising edge
    task automatic drive_cycle();
        req_valid = (next_req < n_req);
        if (next_req < n_req) begin
            req_addr = f_addr[next_req];
            req_op   = f_op[next_req];
        end
        out_ready   = (draw(2) != 0);
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        if (mem_phase == 0 && mem_req) begin
            mem_wait  = draw(2);
            mem_phase = 1;
        end
        if (mem_phase == 1) begin
            if (mem_wait == 0) begin
                mem_addr_ok   = 1'b1;
                mem_line_addr = mem_addr;
                mem_wait      = draw(2);
                mem_phase     = 2;
            end else begin
                mem_wait--;
            end
        end else if (mem_phase == 2) begin
            if (mem_wait == 0) begin
                mem_data_ok = 1'b1;
                // word k of line a is (a + 4k) xor 5a5a0000
                for (int k = 0; k < 4; k++) begin
                    mem_line[k*32 +: 32] = (mem_line_addr + 32'(4 * k)) ^ 32'h5a5a_0000;
                end
                mem_phase = 0;
            end else begin
                mem_wait--;
            end
        end
    endtask

    initial begin
        arst_n = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_op = 1'b0;
        out_ready = 1'b0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line = '0;
        lfsr = 32'h4ac5_b8f3;
        {next_req, n_miss, hs_count, errors, n_pass, n_fail} = '0;
        {idle, drain, mem_phase, mem_wait} = '0;
        {timed_out, stalled, held_sv, held_pair} = '0;
        read_requests();
        if (!file_ok || n_req == 0) begin
            $display("no requests could be read from sim/icache_input.txt");
            errors++;
        end else begin
            repeat (3) @(posedge clk);
            #0.5 arst_n = 1'b1;
            while (!timed_out && drain < DRAIN) begin
                @(negedge clk);
                progress = 1'b0;
                check_cycle();
                idle = progress ? 0 : idle + 1;
                if (idle > WAIT_LIMIT) begin
                    $display("timeout after %0d cycles with no request or output", idle);
                    timed_out = 1'b1;
                end
                if (next_req == n_req && pending.size() == 0) drain++;
                @(posedge clk);
                #0.5;
                drive_cycle();
            end
        end
        $display("%0d requests, %0d passed, %0d failed, %0d errors",
                 n_req, n_pass, n_fail, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_top (
    input  logic        clk,
    input  logic        arst_n,

    // pipeline request
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [31:0] req_addr,
    input  logic        req_op,

    // pipeline result
    output logic        out_valid,
    input  logic        out_ready,
    output logic [63:0] out_pair,
    output logic        out_second_valid,

    // memory port, one line per refill
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  logic [(32<<`ICACHE_OFFSET_W)-1:0] mem_line
);

    lookup_if lk_if ();
    fetch_if  fo_if ();

    logic              hit;
    icache_pkg::line_t hit_line;
    logic              refill_we;
    icache_pkg::line_t refill_line;
    logic              touch;
    logic              invalidate;

    icache_req_buf i_req_buf (
        .clk(clk), .arst_n(arst_n),
        .req_valid(req_valid), .req_ready_unused_guard_n(1'b1),
        .req_addr(req_addr), .req_op(req_op), .req_ready(req_ready),
        .lk(lk_if.source)
    );

    icache_store i_store (
        .clk(clk), .arst_n(arst_n),
        .refill_we(refill_we), .refill_line(refill_line),
        .touch(touch), .invalidate(invalidate),
        .lk(lk_if.monitor), .hit(hit), .hit_line(hit_line)
    );

    icache_ctrl i_ctrl (
        .clk(clk), .arst_n(arst_n),
        .hit(hit), .hit_line(hit_line),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .mem_line(mem_line),
        .lk(lk_if.sink), .fo(fo_if.source),
        .refill_we(refill_we), .refill_line(refill_line),
        .touch(touch), .invalidate(invalidate),
        .mem_req(mem_req), .mem_addr(mem_addr)
    );

    icache_fetch_out i_fetch_out (
        .clk(clk), .arst_n(arst_n), .out_ready(out_ready),
        .fo(fo_if.sink),
        .out_valid(out_valid), .out_pair(out_pair), .out_second_valid(out_second_valid)
    );

endmodule

`default_nettype wire

// File: src/icache_fetch_out.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_fetch_out (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              out_ready,
    fetch_if.sink             fo,
    output logic              out_valid,
    output icache_pkg::pair_t out_pair,
    output logic              out_second_valid
);

    logic [`ICACHE_OFFSET_W-1:0] next_off;
    logic                        last_word;
    icache_pkg::pair_t           sel_pair;
    logic                        sel_second;
    logic                        load;

    //////////////////////////////
    // word pair select
    //////////////////////////////
    assign next_off  = fo.offset + 1'b1;
    assign last_word = &fo.offset;

    always_comb begin
        sel_pair[31:0] = fo.line[fo.offset*32 +: 32];
        if (last_word) begin
            sel_pair[63:32] = `ICACHE_NOP;
            sel_second      = 1'b0;
        end else begin
            sel_pair[63:32] = fo.line[next_off*32 +: 32];
            sel_second      = 1'b1;
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////
    assign fo.ready = !out_valid || out_ready;
    assign load     = fo.valid && fo.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_pair         <= sel_pair;
            out_second_valid <= sel_second;
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_pair) && $stable(out_second_valid)
    );

endmodule

`default_nettype wire

// File: src/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              hit,
    input  icache_pkg::line_t hit_line,
    input  logic              mem_addr_ok,
    input  logic              mem_data_ok,
    input  icache_pkg::line_t mem_line,
    lookup_if.sink            lk,
    fetch_if.source           fo,
    output logic              refill_we,
    output icache_pkg::line_t refill_line,
    output logic              touch,
    output logic              invalidate,
    output logic              mem_req,
    output logic [31:0]       mem_addr
);

    localparam logic [1:0] S_LOOKUP    = 2'd0;
    localparam logic [1:0] S_MISS_REQ  = 2'd1;
    localparam logic [1:0] S_MISS_WAIT = 2'd2;
    localparam logic [1:0] S_HOLD      = 2'd3;

    logic [1:0]                  state_q;
    logic [1:0]                  state_d;
    logic                        res_valid_q;
    icache_pkg::line_t           res_line_q;
    logic [`ICACHE_OFFSET_W-1:0] res_off_q;
    logic                        slot_free;
    logic                        lk_fire;
    logic                        refill_done;
    logic                        is_fetch;
    icache_pkg::fetch_addr_t     line_addr;

    assign is_fetch    = (lk.op == icache_pkg::FETCH);
    assign slot_free   = !res_valid_q || fo.ready;
    assign refill_done = (state_q == S_MISS_WAIT) && mem_data_ok;

    // miss keeps the request in the buffer, the store indexes with it
    always_comb begin
        case (state_q)
            S_LOOKUP:    lk.ready = slot_free && (!is_fetch || hit);
            S_MISS_WAIT: lk.ready = mem_data_ok;
            default:     lk.ready = 1'b0;
        endcase
    end

    assign lk_fire    = lk.valid && lk.ready;
    assign invalidate = (state_q == S_LOOKUP) && lk_fire && !is_fetch;
    assign touch      = (state_q == S_LOOKUP) && lk_fire && is_fetch;

    assign refill_we   = refill_done;
    assign refill_line = mem_line;

    // line aligned memory address
    always_comb begin
        line_addr            = lk.addr;
        line_addr.f.offset   = '0;
        line_addr.f.byte_sel = '0;
    end

    assign mem_req  = (state_q == S_MISS_REQ);
    assign mem_addr = line_addr.raw;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_LOOKUP:    if (lk.valid && is_fetch && !hit && slot_free) state_d = S_MISS_REQ;
            S_MISS_REQ:  if (mem_addr_ok) state_d = S_MISS_WAIT;
            S_MISS_WAIT: if (mem_data_ok) state_d = fo.ready ? S_LOOKUP : S_HOLD;
            default:     if (fo.ready) state_d = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // result slot
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid_q <= 1'b0;
        end else if (touch || (refill_done && !fo.ready)) begin
            res_valid_q <= 1'b1;
        end else if (fo.ready) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (touch || (refill_done && !fo.ready)) begin
            res_line_q <= touch ? hit_line : mem_line;
            res_off_q  <= lk.addr.f.offset;
        end
    end

    // returned line bypasses the slot, which is empty during a miss
    assign fo.valid  = res_valid_q || refill_done;
    assign fo.line   = res_valid_q ? res_line_q : mem_line;
    assign fo.offset = res_valid_q ? res_off_q : lk.addr.f.offset;

    a_req_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_req && !mem_addr_ok |=> mem_req
    );

endmodule

`default_nettype wire

// File: src/icache_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_store (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              refill_we,
    input  icache_pkg::line_t refill_line,
    input  logic              touch,
    input  logic              invalidate,
    lookup_if.monitor         lk,
    output logic              hit,
    output icache_pkg::line_t hit_line
);

    localparam int NSETS = 1 << `ICACHE_INDEX_W;

    logic [1:0][NSETS-1:0]        valid_q;
    logic [NSETS-1:0]             lru_q;
    icache_pkg::tag_t             tag_q  [0:1][0:NSETS-1];
    icache_pkg::line_t            data_q [0:1][0:NSETS-1];

    logic [`ICACHE_INDEX_W-1:0]   idx;
    logic [1:0]                   way_hit;
    logic                         victim;

    assign idx    = lk.addr.f.index;
    assign victim = lru_q[idx];

    //////////////////////////////
    // tag compare, both ways
    //////////////////////////////
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == lk.addr.f.tag);
        end
    end

    assign hit      = lk.valid && (|way_hit);
    assign hit_line = way_hit[1] ? data_q[1][idx] : data_q[0][idx];

    //////////////////////////////
    // valid bits and lru
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (invalidate) begin
            valid_q <= '0;
        end else if (refill_we) begin
            valid_q[victim][idx] <= 1'b1;
        end
    end

    // lru bit names the way to replace next
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;
        end else if (refill_we) begin
            lru_q[idx] <= ~victim;
        end else if (touch) begin
            lru_q[idx] <= ~way_hit[1];
        end
    end

    //////////////////////////////
    // tag and line arrays
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_q[victim][idx]  <= lk.addr.f.tag;
            data_q[victim][idx] <= refill_line;
        end
    end

    // a line is only ever filled into one way after a miss
    a_one_way: assert property (
        @(posedge clk) disable iff (!arst_n)
        lk.valid |-> !(way_hit[0] && way_hit[1])
    );

endmodule

`default_nettype wire

// File: src/icache_req_buf.sv
`timescale 1ns/10ps
`default_nettype none

module icache_req_buf (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  logic     req_ready_unused_guard_n,
    input  logic [31:0] req_addr,
    input  logic     req_op,
    output logic     req_ready,
    lookup_if.source lk
);

    logic                    buf_valid_q;
    logic                    run_q;
    icache_pkg::fetch_addr_t buf_addr_q;
    icache_pkg::req_op_t     buf_op_q;
    logic                    take;

    // free slot, or the held entry leaves this cycle
    assign req_ready = run_q && (!buf_valid_q || lk.ready);
    assign take      = req_valid && req_ready;

    // keeps req_ready low through reset and the first edge after it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= req_ready_unused_guard_n;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid_q <= 1'b0;
        end else if (take) begin
            buf_valid_q <= 1'b1;
        end else if (lk.ready) begin
            buf_valid_q <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (take) begin
            buf_addr_q.raw <= req_addr;
            buf_op_q       <= icache_pkg::req_op_t'(req_op);
        end
    end

    assign lk.valid = buf_valid_q;
    assign lk.addr  = buf_addr_q;
    assign lk.op    = buf_op_q;

    // a stalled lookup keeps its address until consumed
    a_addr_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        lk.valid && !lk.ready |=> lk.valid && $stable(lk.addr)
    );

endmodule

`default_nettype wire

// File: src/icache_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

//////////////////////////////
// request buffer to lookup
//////////////////////////////
interface lookup_if;
    logic                   valid;
    logic                   ready;
    icache_pkg::fetch_addr_t addr;
    icache_pkg::req_op_t     op;

    modport source (
        output valid, addr, op,
        input  ready
    );

    modport sink (
        input  valid, addr, op,
        output ready
    );

    // store only watches the pending lookup
    modport monitor (
        input valid, ready, addr
    );
endinterface

//////////////////////////////
// controller to output stage
//////////////////////////////
interface fetch_if;
    logic                        valid;
    logic                        ready;
    icache_pkg::line_t           line;
    logic [`ICACHE_OFFSET_W-1:0] offset;

    modport source (output valid, line, offset, input ready);

    modport sink (input valid, line, offset, output ready);
endinterface

`default_nettype wire

// File: src/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    // address split: tag | index | word offset | byte
    localparam int TAG_W = 32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - 2;
    localparam int LINE_WORDS = 1 << `ICACHE_OFFSET_W;

    typedef logic [TAG_W-1:0] tag_t;

    typedef logic [LINE_WORDS*32-1:0] line_t;

    // low word is the addressed instruction, high word the next one
    typedef logic [63:0] pair_t;

    typedef enum logic {
        FETCH      = 1'b0,
        INVALIDATE = 1'b1
    } req_op_t;

    // one fetch address, seen as a raw word or as cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            tag_t                        tag;
            logic [`ICACHE_INDEX_W-1:0]  index;
            logic [`ICACHE_OFFSET_W-1:0] offset;
            logic [1:0]                  byte_sel;
        } f;
    } fetch_addr_t;

endpackage

`default_nettype wire

// File: src/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// set index width, 16 sets
`define ICACHE_INDEX_W 4

// word offset within a line, 4 words of 32 bits
`define ICACHE_OFFSET_W 2

// filler for the second slot when the next word is outside the line
// (addi x0, x0, 0)
`define ICACHE_NOP 32'h0000_0013

`endif
